// ==== common/filter_pkg.sv ====
package filter_pkg;

    // one push key per filter
    localparam int NUM_KEYS = 4;

    // bit 0 selects COLOUR up to bit 3 for EDGES
    typedef logic [NUM_KEYS-1:0] key_vec_t;

    // active filter, key number and encoding line up
    typedef enum logic [1:0] {
        COLOUR     = 2'd0,
        BLUR       = 2'd1,
        BRIGHTNESS = 2'd2,
        EDGES      = 2'd3
    } filter_sel_t;

endpackage

// ==== common/pixel_pkg.sv ====
package pixel_pkg;

    // one unsigned colour channel
    localparam int CHANNEL_W = 8;

    // red, green, blue
    localparam int NUM_CHANNELS = 3;

    localparam int PIXEL_W = CHANNEL_W * NUM_CHANNELS;

    // weights 1-2-1 sum to 4, so two extra bits before the divide
    localparam int ACC_W = CHANNEL_W + 2;

    typedef logic [CHANNEL_W-1:0] channel_t;

    // red in the upper byte, blue in the lower byte
    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef logic [ACC_W-1:0] acc_t;

    // saturation ceiling of a channel
    localparam channel_t CHANNEL_MAX = '1;

endpackage

// ==== keys/key_conditioner.sv ====
`timescale 1ns/1ps

module key_conditioner import filter_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 16
) (
    input  logic     clk,
    input  logic     arst_n,
    input  key_vec_t key,
    output key_vec_t key_press
);

    // wide enough to hold DEBOUNCE_CYCLES - 1
    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES) + 1;

    key_vec_t key_meta;
    key_vec_t key_sync;
    key_vec_t key_deb;
    key_vec_t key_deb_q;
    logic [CNT_W-1:0] deb_cnt [NUM_KEYS];

    // two-flop synchroniser, keys are asynchronous to clk
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_meta <= '0;
            key_sync <= '0;
        end else begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    for (genvar k = 0; k < NUM_KEYS; k++) begin : g_debounce
        // count while the synced level disagrees, any agreement restarts it
        always_ff @(posedge clk or negedge arst_n) begin
            if (!arst_n) begin
                deb_cnt[k] <= '0;
                key_deb[k] <= 1'b0;
            end else if (key_sync[k] == key_deb[k]) begin
                deb_cnt[k] <= '0;
            end else if (deb_cnt[k] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
                // stable long enough, follow the input
                deb_cnt[k] <= '0;
                key_deb[k] <= key_sync[k];
            end else begin
                deb_cnt[k] <= deb_cnt[k] + 1'b1;
            end
        end
    end

    // delayed debounced level for the rising edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            key_deb_q <= '0;
        end else begin
            key_deb_q <= key_deb;
        end
    end

    // pulse sits in the first cycle of the new debounced high
    assign key_press = key_deb & ~key_deb_q;

    // a press is a single pulse, never a level
    a_press_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
        (key_press & $past(key_press)) == '0);

endmodule

// ==== keys/filter_fsm.sv ====
`timescale 1ns/1ps

module filter_fsm import filter_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  key_vec_t    key_press,
    output filter_sel_t filter_type
);

    filter_sel_t state;
    filter_sel_t next_state;

    // key n selects filter n
    // scan from the top so the lowest pressed key is assigned last and wins
    always_comb begin
        next_state = state;
        for (int k = NUM_KEYS - 1; k >= 0; k--) begin
            if (key_press[k]) begin
                next_state = filter_sel_t'(k);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= COLOUR;
        end else begin
            state <= next_state;
        end
    end

    assign filter_type = state;

    // the selection only moves one cycle after a press pulse from the key path
    a_change_needs_press: assert property (@(posedge clk) disable iff (!arst_n)
        (filter_type != $past(filter_type)) |-> ($past(key_press) != '0));

endmodule

// ==== filter/pixel_filter.sv ====
`timescale 1ns/1ps

module pixel_filter import filter_pkg::*, pixel_pkg::*; #(
    parameter int BRIGHT_OFFSET = 48
) (
    input  logic        clk,
    input  logic        arst_n,
    input  filter_sel_t filter_type,
    input  logic        in_req,
    output logic        in_ack,
    input  pixel_t      in_pixel,
    input  logic        in_line_start,
    output logic        out_req,
    input  logic        out_ack,
    output pixel_t      out_pixel
);

    // input acknowledged, output requested, then wait for the sink to let go
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IN_ACK,
        ST_OUT_REQ,
        ST_OUT_REL
    } hs_state_t;

    hs_state_t state;
    logic      capture;
    pixel_t    prev1;
    pixel_t    prev2;
    pixel_t    win1;
    pixel_t    win2;
    pixel_t    result;
    channel_t  grey_cur;
    channel_t  grey_prev;
    channel_t  grey_diff;

    // 1-2-1 horizontal weights, floor divide by 4
    function automatic channel_t blur_ch(channel_t a, channel_t b, channel_t c);
        acc_t sum;
        sum = acc_t'(a) + (acc_t'(b) << 1) + acc_t'(c);
        return channel_t'(sum >> 2);
    endfunction

    // add the offset, clamp at full scale
    function automatic channel_t bright_ch(channel_t c);
        logic [CHANNEL_W:0] sum;
        sum = {1'b0, c} + (CHANNEL_W + 1)'(BRIGHT_OFFSET);
        return sum[CHANNEL_W] ? CHANNEL_MAX : sum[CHANNEL_W-1:0];
    endfunction

    // luma approximation, (r + 2g + b) / 4
    function automatic channel_t grey(pixel_t p);
        acc_t sum;
        sum = acc_t'(p[2*CHANNEL_W +: CHANNEL_W])
            + (acc_t'(p[CHANNEL_W +: CHANNEL_W]) << 1)
            + acc_t'(p[0 +: CHANNEL_W]);
        return channel_t'(sum >> 2);
    endfunction

    assign capture = (state == ST_IDLE) && in_req;

    // line start restarts the window from the current pixel
    assign win1 = in_line_start ? in_pixel : prev1;
    assign win2 = in_line_start ? in_pixel : prev2;

    assign grey_cur  = grey(in_pixel);
    assign grey_prev = grey(win1);
    assign grey_diff = (grey_cur > grey_prev) ? grey_cur - grey_prev : grey_prev - grey_cur;

    always_comb begin
        result = in_pixel;
        unique case (filter_type)
            COLOUR: result = in_pixel;
            BLUR: begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    result[ch*CHANNEL_W +: CHANNEL_W] = blur_ch(
                        win2[ch*CHANNEL_W +: CHANNEL_W],
                        win1[ch*CHANNEL_W +: CHANNEL_W],
                        in_pixel[ch*CHANNEL_W +: CHANNEL_W]);
                end
            end
            BRIGHTNESS: begin
                for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                    result[ch*CHANNEL_W +: CHANNEL_W] =
                        bright_ch(in_pixel[ch*CHANNEL_W +: CHANNEL_W]);
                end
            end
            // grey difference replicated on all three channels
            EDGES: result = {NUM_CHANNELS{grey_diff}};
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
            prev1   <= '0;
            prev2   <= '0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (in_req) begin
                        state  <= ST_IN_ACK;
                        in_ack <= 1'b1;
                        // shift the window, win1 already holds the line-start pixel
                        prev2  <= win1;
                        prev1  <= in_pixel;
                    end
                end
                ST_IN_ACK: begin
                    // source released, hand the result to the sink
                    if (!in_req) begin
                        state   <= ST_OUT_REQ;
                        in_ack  <= 1'b0;
                        out_req <= 1'b1;
                    end
                end
                ST_OUT_REQ: begin
                    if (out_ack) begin
                        state   <= ST_OUT_REL;
                        out_req <= 1'b0;
                    end
                end
                ST_OUT_REL: begin
                    // back-pressure, no new capture until the sink drops ack
                    if (!out_ack) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // result is held for the whole output handshake
    always_ff @(posedge clk) begin
        if (capture) begin
            out_pixel <= result;
        end
    end

    a_one_side_active: assert property (@(posedge clk) disable iff (!arst_n)
        !(in_ack && out_req));

    a_ack_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(in_ack) |-> $past(in_req));

endmodule

// ==== src/image_filter_top.sv ====
`timescale 1ns/1ps

module image_filter_top import filter_pkg::*, pixel_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = 16,
    parameter int BRIGHT_OFFSET   = 48
) (
    input  logic        clk,
    input  logic        arst_n,
    input  key_vec_t    key,
    input  logic        in_req,
    output logic        in_ack,
    input  pixel_t      in_pixel,
    input  logic        in_line_start,
    output logic        out_req,
    input  logic        out_ack,
    output pixel_t      out_pixel,
    output filter_sel_t filter_type
);

    // one pulse per debounced press
    key_vec_t key_press;

    key_conditioner #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
    ) u_key_conditioner (
        .clk       (clk),
        .arst_n    (arst_n),
        .key       (key),
        .key_press (key_press)
    );

    // selection is also brought out for observation
    filter_fsm u_filter_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .key_press   (key_press),
        .filter_type (filter_type)
    );

    pixel_filter #(
        .BRIGHT_OFFSET(BRIGHT_OFFSET)
    ) u_pixel_filter (
        .clk           (clk),
        .arst_n        (arst_n),
        .filter_type   (filter_type),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .in_pixel      (in_pixel),
        .in_line_start (in_line_start),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_pixel     (out_pixel)
    );

endmodule

// ==== test/tb_image_filter.sv ====
`timescale 1ns/1ps

module tb_image_filter import filter_pkg::*, pixel_pkg::*; ();

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int BRIGHT_OFFSET = 48;
    localparam logic [31:0] LFSR_SEED = 32'h54b5f286;
    localparam int RUN_PIXELS = 40;
    // colour run, three filter runs and the back-pressure run
    localparam int NUM_PIXELS = 24 + 4 * RUN_PIXELS;
    localparam int KEY_PHASES = 9;
    localparam int TIMEOUT_CYCLES = NUM_PIXELS * 40 + KEY_PHASES * 60;

    logic        clk;
    logic        arst_n;
    key_vec_t    key;
    logic        in_req;
    logic        in_ack;
    pixel_t      in_pixel;
    logic        in_line_start;
    logic        out_req;
    logic        out_ack;
    pixel_t      out_pixel;
    filter_sel_t filter_type;

    // testbench side of the pixel history and the scoreboard
    logic [31:0] pix_lfsr;
    pixel_t      prev1;
    pixel_t      prev2;
    pixel_t      exp_q[$];
    // filter the key presses should have selected
    filter_sel_t exp_filter = COLOUR;
    string       test_name = "reset";
    int          in_count = 0;
    int          out_count = 0;
    int          checks = 0;
    int          errors = 0;
    logic        sink_random = 1'b0;
    logic        out_req_q = 1'b0;

    image_filter_top #(
        .DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
        .BRIGHT_OFFSET  (BRIGHT_OFFSET)
    ) dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .key           (key),
        .in_req        (in_req),
        .in_ack        (in_ack),
        .in_pixel      (in_pixel),
        .in_line_start (in_line_start),
        .out_req       (out_req),
        .out_ack       (out_ack),
        .out_pixel     (out_pixel),
        .filter_type   (filter_type)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Galois form, taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], state[0]};
            state = lfsr_next(state);
        end
    endtask

    // expected pixel straight from the filter rules, integer arithmetic
    function automatic pixel_t expected_pixel(filter_sel_t f, pixel_t cur, pixel_t p1,
                                              pixel_t p2, logic ls);
        pixel_t w1;
        pixel_t w2;
        pixel_t res;
        int     g_cur;
        int     g_prev;
        int     v;
        w1 = ls ? cur : p1;
        w2 = ls ? cur : p2;
        for (int ch = 0; ch < 3; ch++) begin
            v = int'(cur[ch*8 +: 8]);
            if (f == BLUR) begin
                v = (int'(w2[ch*8 +: 8]) + 2 * int'(w1[ch*8 +: 8]) + v) / 4;
            end else if (f == BRIGHTNESS) begin
                v = (v + BRIGHT_OFFSET > 255) ? 255 : v + BRIGHT_OFFSET;
            end
            res[ch*8 +: 8] = v[7:0];
        end
        if (f == EDGES) begin
            g_cur = (int'(cur[23:16]) + 2 * int'(cur[15:8]) + int'(cur[7:0])) / 4;
            g_prev = (int'(w1[23:16]) + 2 * int'(w1[15:8]) + int'(w1[7:0])) / 4;
            v = (g_cur > g_prev) ? g_cur - g_prev : g_prev - g_cur;
            res = {3{v[7:0]}};
        end
        return res;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // source side of the input handshake, expected value queued at send time
    task automatic send_pixel(input pixel_t pix, input logic ls);
        exp_q.push_back(expected_pixel(exp_filter, pix, prev1, prev2, ls));
        prev2 = ls ? pix : prev1;
        prev1 = pix;
        in_pixel = pix;
        in_line_start = ls;
        in_req = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (in_ack);
        in_count++;
    endtask

    // wait until the last output handshake has closed
    task automatic drain();
        while (out_req || out_ack) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_pixels(input string name, input int count, input logic near_full);
        logic [31:0] raw;
        pixel_t      pix;
        test_name = name;
        for (int i = 0; i < count; i++) begin
            draw_bits(pix_lfsr, 24, raw);
            pix = raw[23:0];
            // odd pixels pushed close to full scale for saturation
            if (near_full && (i % 2 == 1)) begin
                pix = pix | 24'hE0E0E0;
            end
            send_pixel(pix, (i % 8) == 0);
        end
        drain();
    endtask

    // hold the keys, release, then let the release debounce too
    task automatic press_keys(input key_vec_t keys, input int hold);
        @(posedge clk);
        #1;
        key = keys;
        repeat (hold) @(posedge clk);
        #1;
        key = '0;
        repeat (DEBOUNCE_CYCLES + 6) @(posedge clk);
        #1;
    endtask

    // sink, optionally waits a random 0..7 cycles before each ack edge
    initial begin : sink
        logic [31:0] sink_lfsr;
        logic [31:0] delay;
        sink_lfsr = LFSR_SEED;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (out_req != out_ack) begin
                if (sink_random) begin
                    draw_bits(sink_lfsr, 3, delay);
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                end
                out_ack = out_req;
            end
        end
    end

    // compare on each rising out_req, sampled mid-cycle
    always @(negedge clk) begin
        if (out_req && !out_req_q) begin
            out_count++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: output transfer with no pixel outstanding", test_name);
            end else begin
                compare_values(test_name, 32'(exp_q.pop_front()), 32'(out_pixel));
            end
        end
        out_req_q = out_req;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout after %0d cycles, test %s did not finish", TIMEOUT_CYCLES, test_name);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int k;
        arst_n = 1'b0;
        key = '0;
        in_req = 1'b0;
        in_pixel = '0;
        in_line_start = 1'b0;
        pix_lfsr = LFSR_SEED;
        prev1 = '0;
        prev2 = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        compare_values("reset_filter", 32'(COLOUR), 32'(filter_type));
        run_pixels("colour", 24, 1'b0);
        // keys 1, 2, 3 and back to 0
        for (int i = 1; i <= NUM_KEYS; i++) begin
            k = i % NUM_KEYS;
            press_keys(key_vec_t'(1 << k), DEBOUNCE_CYCLES + 6);
            compare_values("key_select", 32'(k), 32'(filter_type));
        end
        // too short to pass the debouncer
        press_keys(4'b0100, 2);
        compare_values("key_glitch", 32'(COLOUR), 32'(filter_type));
        press_keys(4'b1010, DEBOUNCE_CYCLES + 6);
        compare_values("key_pair", 32'(BLUR), 32'(filter_type));
        for (int f = 1; f < NUM_KEYS; f++) begin
            press_keys(key_vec_t'(1 << f), DEBOUNCE_CYCLES + 6);
            compare_values("key_select", 32'(f), 32'(filter_type));
            exp_filter = filter_sel_t'(f);
            run_pixels(exp_filter.name(), RUN_PIXELS, exp_filter == BRIGHTNESS);
        end
        sink_random = 1'b1;
        run_pixels("backpressure", RUN_PIXELS, 1'b0);
        compare_values("pixel_count", 32'(in_count), 32'(out_count));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== image_filter_top.f ====
common/filter_pkg.sv
common/pixel_pkg.sv
keys/key_conditioner.sv
keys/filter_fsm.sv
filter/pixel_filter.sv
src/image_filter_top.sv
test/tb_image_filter.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the image filter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f image_filter_top.f \
    --top-module tb_image_filter \
    -o tb_image_filter_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_image_filter_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
